//--- Makefile
SIM   = verilator
FLAGS = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP   = tbFpMiscUnit
FLIST = build.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- build.f
+incdir+test
hw/fpPkg.sv
hw/fpLaneIf.sv
hw/fpUnpack.sv
hw/fpLane.sv
hw/fpIssue.sv
hw/fpCollect.sv
hw/fpMiscUnit.sv
test/tbFpMiscUnit.sv

//--- hw/fpCollect.sv
module fpCollect (
  input  logic          clk,
  input  logic          reset,
  input  logic          ackOut,   // host ack, four phase
  output logic          reqOut,
  output fpPkg::word_t  result,
  output logic          invalid,
  laneResultIf.collector lanes [0:fpPkg::NumLanes-1]
);
  import fpPkg::*;

  typedef enum logic {ColIdle, ColReq} colState_e;

  colState_e           state;
  logic [LaneIdxW-1:0] head;      // oldest request in flight
  logic [LaneIdxW-1:0] takeSel;   // lane being released
  logic                takeQ;
  logic                launch;    // present head result to host
  logic [NumLanes-1:0] fullVec;
  logic [NumLanes-1:0] invVec;
  word_t               resVec [NumLanes];

  // gather lane outputs, scatter take
  for (genvar i = 0; i < NumLanes; i++) begin : gLane
    assign fullVec[i]    = lanes[i].full;
    assign invVec[i]     = lanes[i].invalid;
    assign resVec[i]     = lanes[i].result;
    assign lanes[i].take = takeQ && (takeSel == LaneIdxW'(i));
  end

  ////////////////////
  // handshake
  ////////////////////
  assign launch = (state == ColIdle) && fullVec[head] && !ackOut;  // previous ack gone
  assign reqOut = (state == ColReq);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= ColIdle;
      head    <= '0;
      takeSel <= '0;
      takeQ   <= 1'b0;
    end else begin
      takeQ <= 1'b0;                     // single cycle pulse
      case (state)
        ColIdle: if (launch) state <= ColReq;
        ColReq: begin
          if (ackOut) begin
            state   <= ColIdle;          // req falls with the take pulse
            takeQ   <= 1'b1;
            takeSel <= head;
            head    <= head + 1'b1;      // in request order
          end
        end
        default: state <= ColIdle;
      endcase
    end
  end

  // output hold registers
  always_ff @(posedge clk) begin
    if (launch) begin
      result  <= resVec[head];
      invalid <= invVec[head];
    end
  end

  // data must not move under the host while it is still unacknowledged
  assert property (@(posedge clk) disable iff (reset)
    (reqOut && !ackOut) |=> $stable({result, invalid}));

endmodule

//--- hw/fpIssue.sv
module fpIssue (
  input  logic          clk,
  input  logic          reset,
  input  logic          reqIn,   // host request, four phase
  input  fpPkg::fpOp_e  opIn,
  input  fpPkg::word_t  srcX,
  input  fpPkg::word_t  srcY,
  output logic          ackIn,
  laneIssueIf.issuer    lanes [0:fpPkg::NumLanes-1]
);
  import fpPkg::*;

  typedef enum logic {IssIdle, IssAck} issState_e;

  issState_e           state;
  logic [LaneIdxW-1:0] ptr;      // next lane in round robin
  logic [LaneIdxW-1:0] laneSel;  // lane of the pending issue pulse
  logic [NumLanes-1:0] busyVec;
  logic                accept;   // take the host request this cycle
  logic                issueQ;
  fpOp_e               opQ;
  word_t               xQ, yQ;   // operands captured with the request

  ////////////////////
  // handshake
  ////////////////////
  assign accept = reqIn && (state == IssIdle) && !busyVec[ptr];  // busy lane stalls the host
  assign ackIn  = (state == IssAck);

  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= IssIdle;
      ptr     <= '0;
      laneSel <= '0;
      issueQ  <= 1'b0;
    end else begin
      issueQ <= accept;                   // pulse rises with ackIn
      if (accept) begin
        state   <= IssAck;
        laneSel <= ptr;
        ptr     <= ptr + 1'b1;            // wraps at NumLanes
      end else if (state == IssAck && !reqIn) begin
        state <= IssIdle;                 // host dropped req, drop ack
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      opQ <= opIn;
      xQ  <= srcX;
      yQ  <= srcY;
    end
  end

  ////////////////////
  // lane fan out
  ////////////////////
  for (genvar i = 0; i < NumLanes; i++) begin : gLane
    assign busyVec[i]     = lanes[i].busy;
    assign lanes[i].issue = issueQ && (laneSel == LaneIdxW'(i));
    assign lanes[i].op    = opQ;          // shared, only the pulsed lane latches
    assign lanes[i].srcX  = xQ;
    assign lanes[i].srcY  = yQ;
  end

endmodule

//--- hw/fpLane.sv
module fpLane (
  input logic        clk,
  input logic        reset,
  laneIssueIf.lane   iss,   // op and operands from the issue stage
  laneResultIf.lane  res    // held result toward the collector
);
  import fpPkg::*;

  fpParts_t            x, y;            // unpacked operands
  logic [WordW-2:0]    magX;            // x without its sign
  logic                anyNaN, anySNaN;
  logic                bothZero;        // +0 and -0 compare equal
  logic                eqRaw;           // equal, nan not yet excluded
  logic                ltRaw;           // less-than, nan not yet excluded
  logic                ltSz;            // less-than with -0 below +0
  logic [ClsW-1:0]     clsMask;
  word_t               resNext;
  logic                invNext;
  logic                full;

  fpUnpack uUnpackX (.val(iss.srcX), .parts(x));
  fpUnpack uUnpackY (.val(iss.srcY), .parts(y));

  ////////////////////
  // ordering
  ////////////////////
  assign magX     = {x.exp, x.frac};
  assign anyNaN   = x.isQNaN | x.isSNaN | y.isQNaN | y.isSNaN;
  assign anySNaN  = x.isSNaN | y.isSNaN;
  assign bothZero = x.isZero & y.isZero;
  assign eqRaw    = (iss.srcX == iss.srcY) | bothZero;

  always_comb begin
    if (bothZero)
      ltRaw = 1'b0;
    else if (x.sgn != y.sgn)
      ltRaw = x.sgn;                                   // negative side is smaller
    else if (!x.sgn)
      ltRaw = {x.exp, x.frac} < {y.exp, y.frac};       // both positive
    else
      ltRaw = {x.exp, x.frac} > {y.exp, y.frac};       // both negative, order flips
  end

  assign ltSz = bothZero ? (x.sgn & ~y.sgn) : ltRaw;   // min/max split the zeros

  // classify x, one hot
  always_comb begin
    clsMask             = '0;
    clsMask[ClsNegInf]  = x.isInf  &  x.sgn;
    clsMask[ClsNegNorm] = x.isNorm &  x.sgn;
    clsMask[ClsNegSub]  = x.isSub  &  x.sgn;
    clsMask[ClsNegZero] = x.isZero &  x.sgn;
    clsMask[ClsPosZero] = x.isZero & ~x.sgn;
    clsMask[ClsPosSub]  = x.isSub  & ~x.sgn;
    clsMask[ClsPosNorm] = x.isNorm & ~x.sgn;
    clsMask[ClsPosInf]  = x.isInf  & ~x.sgn;
    clsMask[ClsSNaN]    = x.isSNaN;
    clsMask[ClsQNaN]    = x.isQNaN;
  end

  ////////////////////
  // result select
  ////////////////////
  always_comb begin
    resNext = '0;
    invNext = 1'b0;
    case (iss.op)
      OpSgnj:  resNext = {y.sgn, magX};
      OpSgnjn: resNext = {~y.sgn, magX};
      OpSgnjx: resNext = {x.sgn ^ y.sgn, magX};
      OpEq: begin
        resNext = {{(WordW-1){1'b0}}, eqRaw & ~anyNaN};
        invNext = anySNaN;                             // quiet compare
      end
      OpLt: begin
        resNext = {{(WordW-1){1'b0}}, ltRaw & ~anyNaN};
        invNext = anyNaN;                              // any nan traps
      end
      OpLe: begin
        resNext = {{(WordW-1){1'b0}}, (ltRaw | eqRaw) & ~anyNaN};
        invNext = anyNaN;
      end
      OpMin, OpMax: begin
        if ((x.isQNaN | x.isSNaN) && (y.isQNaN | y.isSNaN))
          resNext = CanonNaN;
        else if (x.isQNaN | x.isSNaN)
          resNext = iss.srcY;                          // the other operand wins
        else if (y.isQNaN | y.isSNaN)
          resNext = iss.srcX;
        else if (iss.op == OpMin)
          resNext = ltSz ? iss.srcX : iss.srcY;
        else
          resNext = ltSz ? iss.srcY : iss.srcX;
        invNext = anySNaN;
      end
      OpClass: resNext = {{(WordW-ClsW){1'b0}}, clsMask};
      default: ;
    endcase
  end

  ////////////////////
  // result hold
  ////////////////////
  always_ff @(posedge clk) begin
    if (reset)
      full <= 1'b0;
    else if (iss.issue)
      full <= 1'b1;                                    // latency of one
    else if (res.take)
      full <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (iss.issue) begin
      res.result  <= resNext;
      res.invalid <= invNext;
    end
  end

  assign res.full = full;
  assign iss.busy = full;  // one result per lane

  // issue stage respects busy, collector only takes what is there
  assert property (@(posedge clk) disable iff (reset) iss.issue |-> !full);
  assert property (@(posedge clk) disable iff (reset) res.take |-> full);

endmodule

//--- hw/fpLaneIf.sv
// issue stage to one lane
interface laneIssueIf;
  import fpPkg::*;

  logic  issue;   // one cycle pulse, only while busy is low
  fpOp_e op;
  word_t srcX;
  word_t srcY;
  logic  busy;    // lane holds a result not yet taken

  modport issuer (output issue, op, srcX, srcY, input busy);
  modport lane   (input issue, op, srcX, srcY, output busy);
endinterface

// one lane to the collector
interface laneResultIf;
  import fpPkg::*;

  logic  full;     // result and invalid are valid
  word_t result;
  logic  invalid;  // nv bit of fflags
  logic  take;     // one cycle pulse, clears full on the next edge

  modport lane      (output full, result, invalid, input take);
  modport collector (input full, result, invalid, output take);
endinterface

//--- hw/fpMiscUnit.sv
module fpMiscUnit (
  input  logic          clk,
  input  logic          reset,
  // request side
  input  logic          reqIn,
  input  fpPkg::fpOp_e  opIn,
  input  fpPkg::word_t  srcX,
  input  fpPkg::word_t  srcY,
  output logic          ackIn,
  // result side
  output logic          reqOut,
  output fpPkg::word_t  result,
  output logic          invalid,   // nv flag of the returned op
  input  logic          ackOut
);
  import fpPkg::*;

  laneIssueIf  issBus [0:NumLanes-1] ();   // issue stage to lanes
  laneResultIf resBus [0:NumLanes-1] ();   // lanes to collector

  ////////////////////
  // issue
  ////////////////////
  fpIssue uIssue (
    .clk,
    .reset,
    .reqIn,
    .opIn,
    .srcX,
    .srcY,
    .ackIn,
    .lanes (issBus)
  );

  // identical lanes, up to NumLanes ops in flight
  for (genvar i = 0; i < NumLanes; i++) begin : gLane
    fpLane uLane (.clk, .reset, .iss(issBus[i]), .res(resBus[i]));
  end

  ////////////////////
  // collect
  ////////////////////
  fpCollect uCollect (
    .clk,
    .reset,
    .ackOut,
    .reqOut,
    .result,
    .invalid,
    .lanes (resBus)
  );

endmodule

//--- hw/fpPkg.sv
package fpPkg;

  ////////////////////
  // lane array
  ////////////////////
  localparam int NumLanes = 4;     // identical lanes, served round robin
  localparam int LaneIdxW = 2;     // width of issue and collect pointers

  ////////////////////
  // single precision
  ////////////////////
  localparam int WordW = 32;       // one fp word or one integer result
  localparam int ExpW  = 8;        // biased exponent
  localparam int FracW = 23;       // stored fraction, hidden bit not kept

  localparam logic [ExpW-1:0]  ExpMax   = 8'd255;        // inf and nan exponent
  localparam logic [WordW-1:0] CanonNaN = 32'h7FC0_0000; // positive quiet nan

  typedef logic [WordW-1:0] word_t;

  // operations of the unit, 9 codes so 4 bits
  typedef enum logic [3:0] {
    OpSgnj,    // magnitude of x, sign of y
    OpSgnjn,   // magnitude of x, inverted sign of y
    OpSgnjx,   // magnitude of x, xor of both signs
    OpEq,      // quiet compare
    OpLt,      // signaling compare
    OpLe,      // signaling compare
    OpMin,
    OpMax,
    OpClass    // ten bit class mask of x
  } fpOp_e;

  ////////////////////
  // classify mask
  ////////////////////
  localparam int ClsW       = 10;  // mask bits used in the integer result
  localparam int ClsNegInf  = 0;
  localparam int ClsNegNorm = 1;
  localparam int ClsNegSub  = 2;
  localparam int ClsNegZero = 3;
  localparam int ClsPosZero = 4;
  localparam int ClsPosSub  = 5;
  localparam int ClsPosNorm = 6;
  localparam int ClsPosInf  = 7;
  localparam int ClsSNaN    = 8;
  localparam int ClsQNaN    = 9;

  // one operand split up, with exactly one class flag set
  typedef struct packed {
    logic             sgn;
    logic [ExpW-1:0]  exp;
    logic [FracW-1:0] frac;
    logic             isZero;
    logic             isSub;   // subnormal
    logic             isNorm;
    logic             isInf;
    logic             isQNaN;
    logic             isSNaN;
  } fpParts_t;

endpackage

//--- hw/fpUnpack.sv
module fpUnpack (
  input  fpPkg::word_t    val,    // raw single precision operand
  output fpPkg::fpParts_t parts   // fields and class flags
);
  import fpPkg::*;

  logic             sgn;
  logic [ExpW-1:0]  exp;
  logic [FracW-1:0] frac;
  logic             expOnes;  // inf or nan
  logic             expZero;  // zero or subnormal
  logic             fracZero;
  logic             quietBit; // fraction msb

  ////////////////////
  // field split
  ////////////////////
  assign sgn  = val[WordW-1];
  assign exp  = val[FracW +: ExpW];
  assign frac = val[FracW-1:0];

  assign expOnes  = (exp == ExpMax);
  assign expZero  = (exp == '0);
  assign fracZero = (frac == '0);
  assign quietBit = frac[FracW-1];

  ////////////////////
  // class flags
  ////////////////////
  always_comb begin
    parts.sgn  = sgn;
    parts.exp  = exp;
    parts.frac = frac;

    // exponent zero, no implicit one
    parts.isZero = expZero & fracZero;
    parts.isSub  = expZero & ~fracZero;

    // anything between the two reserved exponents
    parts.isNorm = ~expZero & ~expOnes;

    // reserved exponent, fraction tells inf from nan
    parts.isInf  = expOnes & fracZero;
    parts.isQNaN = expOnes & quietBit;
    parts.isSNaN = expOnes & ~quietBit & ~fracZero;  // payload without quiet bit
  end

endmodule

//--- test/fpRefModel.svh
////////////////////
// word level tests
////////////////////
function automatic logic isNaNw(word_t w);
  return (w[30:23] == 8'hFF) && (w[22:0] != '0);  // reserved exponent with payload
endfunction

function automatic logic isSNaNw(word_t w);
  return isNaNw(w) && !w[22];  // quiet bit clear
endfunction

// signed key for ordering, both zeros land on 0
function automatic longint orderKey(word_t w);
  longint mag;
  mag = longint'({33'b0, w[30:0]});
  return w[31] ? -mag : mag;
endfunction

// one hot class of a word
function automatic logic [ClsW-1:0] classMask(word_t w);
  logic [ClsW-1:0] m;
  logic            s;
  logic [7:0]      e;
  logic [22:0]     f;
  m = '0;
  s = w[31];
  e = w[30:23];
  f = w[22:0];
  if (e == 8'hFF) begin
    if (f == '0)
      m[s ? ClsNegInf : ClsPosInf] = 1'b1;
    else if (f[22])
      m[ClsQNaN] = 1'b1;
    else
      m[ClsSNaN] = 1'b1;
  end else if (e == 8'h00) begin
    if (f == '0)
      m[s ? ClsNegZero : ClsPosZero] = 1'b1;
    else
      m[s ? ClsNegSub : ClsPosSub] = 1'b1;  // no hidden one
  end else begin
    m[s ? ClsNegNorm : ClsPosNorm] = 1'b1;
  end
  return m;
endfunction

////////////////////
// expected {invalid, result}
////////////////////
function automatic logic [32:0] refCompute(fpOp_e op, word_t x, word_t y);
  logic   inv;
  word_t  res;
  logic   xn, yn;
  logic   xSmaller;  // min/max pick, -0 below +0
  longint kx, ky;
  inv = 1'b0;
  res = '0;
  xn  = isNaNw(x);
  yn  = isNaNw(y);
  kx  = orderKey(x);
  ky  = orderKey(y);
  case (op)
    OpSgnj:  res = {y[31], x[30:0]};
    OpSgnjn: res = {~y[31], x[30:0]};
    OpSgnjx: res = {x[31] ^ y[31], x[30:0]};
    OpEq: begin
      res = {31'b0, !xn && !yn && (kx == ky)};
      inv = isSNaNw(x) || isSNaNw(y);        // quiet nan does not trap
    end
    OpLt: begin
      res = {31'b0, !xn && !yn && (kx < ky)};
      inv = xn || yn;
    end
    OpLe: begin
      res = {31'b0, !xn && !yn && (kx <= ky)};
      inv = xn || yn;
    end
    OpMin, OpMax: begin
      if (kx != ky)
        xSmaller = (kx < ky);
      else
        xSmaller = x[31];                    // signed zeros split here
      if (xn && yn)
        res = CanonNaN;
      else if (xn)
        res = y;
      else if (yn)
        res = x;
      else
        res = ((op == OpMin) == xSmaller) ? x : y;
      inv = isSNaNw(x) || isSNaNw(y);
    end
    OpClass: res = {22'b0, classMask(x)};
    default: ;
  endcase
  return {inv, res};
endfunction

//--- test/tbFpMiscUnit.sv
module tbFpMiscUnit;
  timeunit 1ns;
  timeprecision 1ps;
  import fpPkg::*;

  localparam int          NumReqs   = 2000;
  localparam int          WaitLimit = 200;          // cycles per wait
  localparam logic [31:0] Seed      = 32'h79070433;

  typedef struct packed {
    fpOp_e op;
    logic  inv;
    word_t res;
  } expect_t;

  logic  clk, reset;
  logic  reqIn, ackIn;
  fpOp_e opIn;
  word_t srcX, srcY;
  logic  reqOut, ackOut;
  word_t result;
  logic  invalid;

  expect_t     expQ [$];          // in request order
  logic [31:0] drvState;          // driver lcg
  logic [31:0] ackState;          // receiver lcg, ack delays
  int          checkErrs;
  int          outstanding;       // accepted but not yet acked
  logic        ackInPrev, ackOutPrev;

  `include "fpRefModel.svh"

  fpMiscUnit UUT (
    .clk, .reset,
    .reqIn, .opIn, .srcX, .srcY, .ackIn,
    .reqOut, .result, .invalid, .ackOut
  );

  always #2 clk = ~clk;  // 4 ns period

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] lcgNext(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function logic [31:0] drvRand();
    drvState = lcgNext(drvState);
    return drvState;
  endfunction

  task reportFail(input string what);
    checkErrs++;
    $display("TEST FAILED");
    $display("%s", what);
    $fatal(1, "stopped at first error");
  endtask

  // operand biased toward zeros, inf, nans and subnormals
  function automatic word_t specialOperand();
    logic [31:0] r, p, q;
    logic        sgn;
    word_t       w;
    r   = drvRand();
    p   = drvRand();
    q   = drvRand();
    sgn = p[31];
    case (r[31:29])
      3'd0:    w = {sgn, 31'h0};
      3'd1:    w = {sgn, ExpMax, 23'h0};
      3'd2:    w = {sgn, ExpMax, 1'b1, p[21:0]};          // quiet
      3'd3:    w = {sgn, ExpMax, 1'b0, p[21:1], 1'b1};    // signaling, payload never 0
      3'd4:    w = {sgn, 8'h00, p[22:1], 1'b1};
      3'd5:    w = {sgn, 6'b011111, q[31:30], q[29:7]};   // normals near 1.0
      default: w = {sgn, p[30:16], q[31:16]};
    endcase
    return w;
  endfunction

  ////////////////////
  // driver
  ////////////////////
  task sendRequest(input int idx);
    logic [31:0] r;
    fpOp_e       op;
    word_t       x, y;
    expect_t     e;
    int          cycles;
    r  = drvRand();
    op = fpOp_e'(4'(r[31:16] % 16'd9));
    x  = specialOperand();
    r  = drvRand();
    case (r[31:30])
      2'd0:    y = x;                      // equal pair
      2'd1:    y = {~x[31], x[30:0]};      // same magnitude, other sign
      default: y = specialOperand();
    endcase
    e.op = op;
    {e.inv, e.res} = refCompute(op, x, y);
    expQ.push_back(e);
    opIn  = op;
    srcX  = x;
    srcY  = y;
    reqIn = 1'b1;
    cycles = 0;
    while (!ackIn) begin
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles <= WaitLimit)
        else reportFail($sformatf("timeout waiting for ackIn to rise, request %0d", idx));
    end
    reqIn  = 1'b0;
    cycles = 0;
    while (ackIn) begin
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles <= WaitLimit)
        else reportFail($sformatf("timeout waiting for ackIn to fall, request %0d", idx));
    end
    repeat (r[29:28]) begin           // short idle gap
      @(posedge clk);
      #1;
    end
  endtask

  ////////////////////
  // receiver
  ////////////////////
  task receiveResult(input int idx);
    expect_t e;
    int      cycles;
    cycles = 0;
    while (!reqOut) begin
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles <= WaitLimit)
        else reportFail($sformatf("timeout waiting for result %0d", idx));
    end
    assert (expQ.size() > 0)
      else reportFail("a result arrived with no request outstanding");
    e = expQ.pop_front();
    // mask shape first, independent of the model
    if (e.op == OpClass) begin
      assert ($countones(result[ClsW-1:0]) == 1)
        else reportFail($sformatf("mismatch %s #%0d mask bits set: expected 1, actual %0d",
                                  e.op.name(), idx, $countones(result[ClsW-1:0])));
    end
    assert (result == e.res)
      else reportFail($sformatf("mismatch %s #%0d result: expected %h, actual %h",
                                e.op.name(), idx, e.res, result));
    assert (invalid == e.inv)
      else reportFail($sformatf("mismatch %s #%0d invalid: expected %0b, actual %0b",
                                e.op.name(), idx, e.inv, invalid));
    ackState = lcgNext(ackState);
    repeat (ackState[27:24]) begin     // 0 to 15 cycles, lets lanes fill
      @(posedge clk);
      #1;
    end
    ackOut = 1'b1;
    cycles = 0;
    while (reqOut) begin
      @(posedge clk);
      #1;
      cycles++;
      assert (cycles <= WaitLimit)
        else reportFail($sformatf("timeout waiting for reqOut to fall, result %0d", idx));
    end
    ackOut = 1'b0;
  endtask

  // requests in flight never exceed the lane count
  always @(negedge clk) begin
    if (reset) begin
      outstanding = 0;
      ackInPrev   = 1'b0;
      ackOutPrev  = 1'b0;
    end else begin
      if (ackIn && !ackInPrev)
        outstanding++;
      if (ackOut && !ackOutPrev)
        outstanding--;               // lane frees after this ack
      ackInPrev  = ackIn;
      ackOutPrev = ackOut;
      assert (outstanding <= NumLanes)
        else reportFail($sformatf("ackIn rose with all lanes full, %0d in flight", outstanding));
    end
  end

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    clk       = 1'b0;
    reset     = 1'b1;
    reqIn     = 1'b0;
    opIn      = OpSgnj;
    srcX      = '0;
    srcY      = '0;
    ackOut    = 1'b0;
    drvState  = Seed;
    ackState  = Seed ^ 32'hA5A5_5A5A;   // separate stream for ack delays
    checkErrs = 0;
    repeat (4) begin
      @(posedge clk);
      #1;
      assert (!ackIn && !reqOut)
        else reportFail("ackIn or reqOut high during reset");
    end
    reset = 1'b0;
    @(posedge clk);
    #1;
    assert (!ackIn && !reqOut)
      else reportFail("ackIn or reqOut high on the first cycle after reset");
    fork
      begin
        for (int i = 0; i < NumReqs; i++)
          sendRequest(i);
      end
      begin
        for (int i = 0; i < NumReqs; i++)
          receiveResult(i);
      end
    join
    if (checkErrs == 0)
      $display("TEST PASSED");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
